//--- hw/imul_dpath.sv
// multiplier datapath
// operand magnitudes, shift-and-add accumulator and final sign correction
`timescale 1ns/1ps
`default_nettype none

module imul_dpath import imul_pkg::*; (
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire imul_req_t req_msg,
  // control from the FSM
  input  wire logic      a_en,
  input  wire logic      a_mux_sel,
  input  wire logic      b_en,
  input  wire logic      b_mux_sel,
  input  wire logic      result_clr,
  output imul_resp_t     resp_msg
);

  // shifted multiplicand growing into the upper half
  logic [imul_prod_w-1:0] a_reg;
  // multiplier consumed from the lsb
  logic [imul_data_w-1:0] b_reg;
  logic [imul_prod_w-1:0] result_reg;
  // product sign latched at acceptance
  logic                   sign_reg;

  logic [imul_data_w-1:0] a_raw;
  logic [imul_data_w-1:0] b_raw;
  logic [imul_data_w-1:0] a_mag;
  logic [imul_data_w-1:0] b_mag;
  logic [imul_prod_w-1:0] a_mux_out;
  logic [imul_data_w-1:0] b_mux_out;
  logic                   load;
  logic                   step;

  // --------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------
  assign a_raw = req_msg.a;
  assign b_raw = req_msg.b;
  // -2^31 comes out as 0x80000000 and reads as unsigned 2^31
  assign a_mag = a_raw[imul_data_w-1] ? (~a_raw + 1'b1) : a_raw;
  assign b_mag = b_raw[imul_data_w-1] ? (~b_raw + 1'b1) : b_raw;

  // select 0 loads the new operands and select 1 takes the shifted value
  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {{imul_data_w{1'b0}}, a_mag};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : b_mag;

  assign load = a_en && !a_mux_sel;
  assign step = a_en && a_mux_sel;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
  end

  // accumulator and sign
  always_ff @(posedge clk) begin
    if (reset) begin
      result_reg <= '0;
      sign_reg   <= 1'b0;
    end else begin
      if (result_clr) begin
        result_reg <= '0;
      end else if (step && b_reg[0]) begin
        // add the multiplicand when the current multiplier bit is set
        result_reg <= result_reg + a_reg;
      end
      if (load) begin
        sign_reg <= req_msg.a[imul_data_w-1] ^ req_msg.b[imul_data_w-1];
      end
    end
  end

  // two's complement negate for a negative product
  assign resp_msg.result = sign_reg ? (~result_reg + 1'b1) : result_reg;

endmodule

`default_nettype wire

//--- hw/imul_iterative.sv
// iterative multiplier
// FSM and step counter sequencing 32 add/shift steps in the datapath
`timescale 1ns/1ps
`default_nettype none

module imul_iterative import imul_pkg::*; (
  input  wire logic       clk,
  input  wire logic       reset,
  // request side
  input  wire imul_req_t  req_msg,
  input  wire logic       req_val,
  output logic            req_rdy,
  // response side
  output imul_resp_t      resp_msg,
  output logic            resp_val,
  input  wire logic       resp_rdy
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  state_t                state;
  logic [imul_cnt_w-1:0] count;
  logic                  req_go;
  logic                  resp_go;

  // datapath control
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;
  logic result_clr;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------------------
  // state and step counter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // one add/shift per cycle for count 0 to 31
          if (count == imul_last_step) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // back-pressure just holds us here
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // outputs decoded from state only
  // --------------------------------------------------
  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    a_en       = 1'b0;
    a_mux_sel  = 1'b0;
    b_en       = 1'b0;
    b_mux_sel  = 1'b0;
    result_clr = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        // load magnitudes and sign while clearing the accumulator
        a_en       = req_go;
        b_en       = req_go;
        result_clr = req_go;
      end
      st_calc: begin
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
        b_en      = 1'b1;
        b_mux_sel = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
      end
    endcase
  end

  imul_dpath i_dpath (
    .clk        (clk),
    .reset      (reset),
    .req_msg    (req_msg),
    .a_en       (a_en),
    .a_mux_sel  (a_mux_sel),
    .b_en       (b_en),
    .b_mux_sel  (b_mux_sel),
    .result_clr (result_clr),
    .resp_msg   (resp_msg)
  );

endmodule

`default_nettype wire

//--- hw/imul_pkg.sv
// imul package
// operand and product widths, step counter and the request/response messages
`default_nettype none

package imul_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int imul_data_w = 32;
  // full signed product
  localparam int imul_prod_w = 2 * imul_data_w;
  // step counter covering imul_data_w steps
  localparam int imul_cnt_w = 6;
  // count value of the final add/shift step
  localparam logic [imul_cnt_w-1:0] imul_last_step = imul_cnt_w'(imul_data_w - 1);

  // --------------------------------------------------
  // messages
  // --------------------------------------------------
  // request with one signed operand pair
  typedef struct packed {
    logic signed [imul_data_w-1:0] a;
    logic signed [imul_data_w-1:0] b;
  } imul_req_t;

  // response carrying the signed product
  typedef struct packed {
    logic signed [imul_prod_w-1:0] result;
  } imul_resp_t;

endpackage

`default_nettype wire

//--- hw/imul_unit.sv
// multiply unit top
// request queue, iterative signed multiplier and response queue
`timescale 1ns/1ps
`default_nettype none

module imul_unit import imul_pkg::*; #(
  parameter int req_depth  = 4,
  parameter int resp_depth = 2
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  // operand pair in
  input  wire logic signed [imul_data_w-1:0] req_a,
  input  wire logic signed [imul_data_w-1:0] req_b,
  input  wire logic                          req_val,
  output logic                               req_rdy,
  // product out
  output logic signed [imul_prod_w-1:0]      resp_result,
  output logic                               resp_val,
  input  wire logic                          resp_rdy
);

  imul_req_t  in_req;
  imul_req_t  q_req_msg;
  logic       q_req_val;
  logic       q_req_rdy;
  imul_resp_t m_resp_msg;
  logic       m_resp_val;
  logic       m_resp_rdy;
  imul_resp_t out_resp;

  // pack the operands into a request message
  assign in_req.a    = req_a;
  assign in_req.b    = req_b;
  assign resp_result = out_resp.result;

  // --------------------------------------------------
  // request queue -> multiplier -> response queue
  // --------------------------------------------------
  msg_fifo #(
    .depth     (req_depth),
    .payload_t (imul_req_t)
  ) i_req_q (
    .clk     (clk),
    .reset   (reset),
    .in_msg  (in_req),
    .in_val  (req_val),
    .in_rdy  (req_rdy),
    .out_msg (q_req_msg),
    .out_val (q_req_val),
    .out_rdy (q_req_rdy)
  );

  imul_iterative i_mul (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (q_req_msg),
    .req_val  (q_req_val),
    .req_rdy  (q_req_rdy),
    .resp_msg (m_resp_msg),
    .resp_val (m_resp_val),
    .resp_rdy (m_resp_rdy)
  );

  // holds finished products while the consumer stalls
  msg_fifo #(
    .depth     (resp_depth),
    .payload_t (imul_resp_t)
  ) i_resp_q (
    .clk     (clk),
    .reset   (reset),
    .in_msg  (m_resp_msg),
    .in_val  (m_resp_val),
    .in_rdy  (m_resp_rdy),
    .out_msg (out_resp),
    .out_val (resp_val),
    .out_rdy (resp_rdy)
  );

endmodule

`default_nettype wire

//--- hw/msg_fifo.sv
// message FIFO
// valid/ready circular buffer generic over depth and payload type
`timescale 1ns/1ps
`default_nettype none

module msg_fifo #(
  parameter int  depth     = 2,
  parameter type payload_t = logic [7:0]
) (
  input  wire logic     clk,
  input  wire logic     reset,
  // enqueue side
  input  wire payload_t in_msg,
  input  wire logic     in_val,
  output logic          in_rdy,
  // dequeue side
  output payload_t      out_msg,
  output logic          out_val,
  input  wire logic     out_rdy
);

  // pointers wrap on their own since depth is a power of two
  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = ptr_w + 1;

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  // occupancy from 0 to depth
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;

  // not full regardless of out_rdy
  assign in_rdy  = (count != cnt_w'(depth));
  assign out_val = (count != '0);
  assign push    = in_val && in_rdy;
  assign pop     = out_val && out_rdy;
  // head entry with no bypass from the input
  assign out_msg = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_msg;
    end
  end

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- list.f
hw/imul_pkg.sv
hw/msg_fifo.sv
hw/imul_dpath.sv
hw/imul_iterative.sv
hw/imul_unit.sv
test/imul_unit_checker.sv
test/imul_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the multiply unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module imul_unit_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vimul_unit_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0

//--- test/imul_unit_checker.sv
// handshake checker for the multiply unit
// bound into imul_unit to watch the response hold and the state after reset
`timescale 1ns/1ps
`default_nettype none

module imul_unit_checker import imul_pkg::*; (
  input wire logic                          clk,
  input wire logic                          reset,
  input wire logic                          req_rdy,
  input wire logic                          resp_val,
  input wire logic                          resp_rdy,
  input wire logic signed [imul_prod_w-1:0] resp_result
);

  // a stalled response keeps valid up
  property resp_val_held;
    @(posedge clk) disable iff (reset) (resp_val && !resp_rdy) |=> resp_val;
  endproperty

  // and keeps its product steady
  property resp_result_held;
    @(posedge clk) disable iff (reset) (resp_val && !resp_rdy) |=> $stable(resp_result);
  endproperty

  // queues empty in the first cycle out of reset
  property reset_state;
    @(posedge clk) $fell(reset) |-> (req_rdy && !resp_val);
  endproperty

  a_resp_val_held: assert property (resp_val_held)
    else $error("resp_val dropped before the response was taken");
  a_resp_result_held: assert property (resp_result_held)
    else $error("resp_result changed while the response was stalled");
  a_reset_state: assert property (reset_state)
    else $error("unit not idle in the first cycle after reset");

endmodule

bind imul_unit imul_unit_checker i_checker (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

`default_nettype wire

//--- test/imul_unit_tb.sv
// testbench for the multiply unit
// directed, random, back-pressure and burst tests against a reference product
`timescale 1ns/1ps
`default_nettype none

module imul_unit_tb import imul_pkg::*;;

  localparam int req_depth   = 4;
  localparam int resp_depth  = 2;
  localparam int send_limit  = 200;
  localparam int drain_limit = 2000;
  localparam int n_dir       = 12;

  // directed corner pairs
  localparam logic signed [imul_data_w-1:0] dir_a [n_dir] = '{
    32'sd0, 32'sd123456, 32'sd1, -32'sd1, -32'sd1, 32'sd1000,
    -32'sd46341, 32'sh80000000, 32'sh80000000, 32'sh7fffffff, 32'sh80000000, 32'sh7fffffff
  };
  localparam logic signed [imul_data_w-1:0] dir_b [n_dir] = '{
    32'sd123456, 32'sd0, 32'sd1, 32'sd1, -32'sd1, -32'sd3000,
    -32'sd46341, 32'sh80000000, 32'sd1, 32'sh7fffffff, -32'sd1, 32'sh80000000
  };

  logic                          clk;
  logic                          reset;
  logic signed [imul_data_w-1:0] req_a;
  logic signed [imul_data_w-1:0] req_b;
  logic                          req_val;
  logic                          req_rdy;
  logic signed [imul_prod_w-1:0] resp_result;
  logic                          resp_val;
  logic                          resp_rdy;

  // resp_rdy comes from a steady level or from random toggling
  logic        rdy_hold;
  logic        bp_mode;
  logic [31:0] rng;
  logic [31:0] rng_bp;

  imul_resp_t exp_q[$];
  int         err_count;
  int         n_checks;
  int         n_tests;
  int         n_accept;
  int         n_resp;

  imul_unit #(
    .req_depth  (req_depth),
    .resp_depth (resp_depth)
  ) i_imul_unit (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------
  // reference model and helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // full signed product with both operands sign extended to 64 bits
  function automatic imul_resp_t ref_mul(input logic signed [imul_data_w-1:0] a,
                                         input logic signed [imul_data_w-1:0] b);
    imul_resp_t r;
    longint     sa;
    longint     sb;
    sa = a;
    sb = b;
    r.result = sa * sb;
    return r;
  endfunction

  task automatic compare_resp(input imul_resp_t got, input imul_resp_t exp, input string name);
    n_checks++;
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got.result, exp.result);
      err_count++;
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string name);
    n_checks++;
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string name);
    n_checks++;
    if (got != exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  // sends one request and returns on its handshake edge
  task automatic send(input logic signed [imul_data_w-1:0] a,
                      input logic signed [imul_data_w-1:0] b);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    while (!done && n < send_limit) begin
      @(posedge clk);
      n++;
      done = req_rdy;
    end
    if (!done) begin
      $display("timeout: request not accepted within %0d cycles", send_limit);
      err_count++;
    end
    req_val <= 1'b0;
  endtask

  // wait until every accepted request has its response
  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < drain_limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d responses still missing", exp_q.size());
      err_count++;
    end
  endtask

  task automatic test_done(input string name, input int err_before);
    n_tests++;
    $display("test %s %s", name, (err_count == err_before) ? "pass" : "errors");
  endtask

  // --------------------------------------------------
  // resp_rdy driver
  // --------------------------------------------------
  always @(posedge clk) begin
    if (bp_mode) begin
      rng_bp = xorshift(rng_bp);
      resp_rdy <= rng_bp[3];
    end else begin
      resp_rdy <= rdy_hold;
    end
  end

  // scoreboard pushes on a request handshake and pops and compares on a response
  always @(posedge clk) begin
    imul_resp_t got;
    if (!reset && req_val && req_rdy) begin
      exp_q.push_back(ref_mul(req_a, req_b));
      n_accept++;
    end
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("response at %0t with no request outstanding", $time);
        err_count++;
      end else begin
        got.result = resp_result;
        compare_resp(got, exp_q.pop_front(), "resp_result");
      end
      n_resp++;
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int start;
    int a0;
    int r0;
    int n;
    int stall;
    int burst;
    logic signed [imul_data_w-1:0] a;
    logic signed [imul_data_w-1:0] b;

    clk       = 1'b0;
    reset     = 1'b1;
    req_a     = '0;
    req_b     = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    rdy_hold  = 1'b0;
    bp_mode   = 1'b0;
    rng       = 32'h8017;
    // separate stream for resp_rdy
    rng_bp    = ~32'h8017;
    err_count = 0;
    n_checks  = 0;
    n_tests   = 0;
    n_accept  = 0;
    n_resp    = 0;

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // reset state
    start = err_count;
    @(posedge clk);
    compare_bit(resp_val, 1'b0, "resp_val");
    compare_bit(req_rdy, 1'b1, "req_rdy");
    rdy_hold <= 1'b1;
    repeat (2) @(posedge clk);
    test_done("reset", start);

    // single request latency counted from the handshake edge
    start = err_count;
    send(32'sd123456, -32'sd789);
    n = 0;
    while (!resp_val && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (!resp_val) begin
      $display("timeout: no response within 100 cycles");
      err_count++;
    end
    // first sampled high one edge after it rose
    compare_count(n - 1, 34, "latency");
    drain();
    test_done("latency", start);

    // signed corner cases
    start = err_count;
    a0 = n_accept;
    r0 = n_resp;
    for (int i = 0; i < n_dir; i++) begin
      send(dir_a[i], dir_b[i]);
    end
    drain();
    compare_count(n_resp - r0, n_accept - a0, "responses");
    test_done("directed", start);

    // random back-to-back stream
    start = err_count;
    a0 = n_accept;
    r0 = n_resp;
    for (int i = 0; i < 200; i++) begin
      rng = xorshift(rng);
      a = rng;
      rng = xorshift(rng);
      b = rng;
      send(a, b);
    end
    drain();
    compare_count(n_resp - r0, n_accept - a0, "responses");
    test_done("random", start);

    // back-pressure with gaps in the request stream
    start = err_count;
    a0 = n_accept;
    r0 = n_resp;
    bp_mode <= 1'b1;
    for (int i = 0; i < 80; i++) begin
      rng = xorshift(rng);
      if (rng[0]) begin
        @(posedge clk);
      end
      rng = xorshift(rng);
      a = rng;
      rng = xorshift(rng);
      b = rng;
      send(a, b);
    end
    bp_mode <= 1'b0;
    drain();
    compare_count(n_resp - r0, n_accept - a0, "responses");
    test_done("backpressure", start);

    // fill every stage with the output stalled
    start = err_count;
    rdy_hold <= 1'b0;
    repeat (2) @(posedge clk);
    a0 = n_accept;
    r0 = n_resp;
    rng = xorshift(rng);
    req_a <= rng;
    rng = xorshift(rng);
    req_b <= rng;
    req_val <= 1'b1;
    stall = 0;
    n = 0;
    while (stall < 100 && n < 1000) begin
      @(posedge clk);
      n++;
      if (req_rdy) begin
        stall = 0;
        rng = xorshift(rng);
        req_a <= rng;
        rng = xorshift(rng);
        req_b <= rng;
      end else begin
        stall++;
      end
    end
    req_val <= 1'b0;
    burst = n_accept - a0;
    if (stall < 100) begin
      $display("req_rdy never stayed low with the output stalled");
      err_count++;
    end
    if (burst > req_depth + resp_depth + 1) begin
      $display("unit accepted %0d requests while stalled", burst);
      err_count++;
    end
    rdy_hold <= 1'b1;
    drain();
    compare_count(n_resp - r0, burst, "burst responses");
    test_done("burst", start);

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
